//--- adc_ctrl_top.f
common/adc_pkg.sv
common/spi_pkg.sv
verilog/sync_edge.sv
spi/spi_slave.sv
verilog/phase_counter.sv
verilog/adc_seq_fsm.sv
verilog/adc_ctrl_top.sv
tests/tb_adc_ctrl_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
	  -f adc_ctrl_top.f --top-module tb_adc_ctrl_top -o tb_adc_ctrl_top
	./obj_dir/tb_adc_ctrl_top | tee /dev/stderr | grep -F "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- tests/tb_adc_ctrl_top.sv
// testbench for the ADC controller that runs SPI frames and a comparator model against the DUT
`timescale 1ns/1ns

module tb_adc_ctrl_top;

  import adc_pkg::*;
  import spi_pkg::*;

  localparam logic [count_w-1:0] reset_cycles = 40;
  localparam logic [count_w-1:0] runup_cycles = 200;
  localparam int unsigned wait_limit = 2000;

  logic clk;
  logic arst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic t_trigger;
  logic miso;
  logic m_reset;
  logic m_in;
  logic m_ref;

  // comparator output and a manual override for the out-of-phase check
  logic cmp_out = 1'b0;
  logic manual_trig;
  logic cmp_m_in_prev = 1'b0;
  logic m_reset_prev = 1'b0;
  logic m_in_prev = 1'b0;

  int unsigned cyc = 0;
  int unsigned start_count;
  int unsigned seen_starts = 0;
  int unsigned countdown = 0;
  int unsigned conv_ends = 0;
  int unsigned ends_before;
  int unsigned rise_cyc = 0;
  int unsigned fall_cyc = 0;
  int unsigned trig_cyc = 0;
  int unsigned gap;
  int unsigned meas;
  int unsigned byte_end_cyc [4] = '{0, 0, 0, 0};
  int unsigned seed;
  int unsigned n;
  int unsigned k;
  logic [count_w-1:0] rdata;
  logic [count_w-1:0] rdata2;

  assign t_trigger = cmp_out | manual_trig;

  adc_ctrl_top #(
    .RESET_CYCLES (reset_cycles),
    .RUNUP_CYCLES (runup_cycles)
  ) adc_ctrl_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck       (sck),
    .ssel      (ssel),
    .mosi      (mosi),
    .t_trigger (t_trigger),
    .miso      (miso),
    .m_reset   (m_reset),
    .m_in      (m_in),
    .m_ref     (m_ref)
  );

  ////////////////////////////////////////////////////////////
  // clock and failure reporting
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  ////////////////////////////////////////////////////////////
  // SPI host in mode 0 with sck at clk/8
  ////////////////////////////////////////////////////////////

  // 32-bit frame with the opcode byte in one slot and 0x00 in the rest
  task automatic spi_xfer(input logic [31:0] word, output logic [31:0] rd);
    int i;
    rd = '0;
    // a start frame also resets the comparator model
    if (word[7:0] == op_start)
      start_count <= start_count + 1;
    @(negedge clk);
    ssel = 1'b0;
    // give the slave time to load its snapshot
    repeat (8) @(negedge clk);
    for (i = 0; i < 32; i++)
    begin
      mosi = word[31 - i];
      repeat (4) @(negedge clk);
      // miso is sampled just before the rising sck
      rd  = {rd[30:0], miso};
      sck = 1'b1;
      if ((i % 8) == 7)
        byte_end_cyc[i / 8] = cyc;
      repeat (4) @(negedge clk);
      sck = 1'b0;
    end
    repeat (4) @(negedge clk);
    ssel = 1'b1;
    mosi = 1'b0;
    repeat (8) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // comparator model
  ////////////////////////////////////////////////////////////

  // fires a random 50 to 300 cycles into run-down and drops on each start
  always @(negedge clk)
  begin
    if (start_count != seen_starts)
    begin
      seen_starts = start_count;
      cmp_out     = 1'b0;
      countdown   = 0;
    end
    else if (m_in && !cmp_m_in_prev)
      countdown = 50 + ($urandom % 251);
    else if (countdown != 0)
    begin
      countdown = countdown - 1;
      if (countdown == 0)
      begin
        cmp_out  = 1'b1;
        trig_cyc = cyc;
      end
    end
    cmp_m_in_prev = m_in;
  end

  ////////////////////////////////////////////////////////////
  // switch monitor
  ////////////////////////////////////////////////////////////

  // input and reference switches never close together
  assert property (@(posedge clk) disable iff (!arst_n) m_ref == !m_in)
  else flag_mismatch("m_ref", 32'($sampled(m_ref)), 32'(!$sampled(m_in)));

  // run-down ends with both switches released on the same edge
  assert property (@(posedge clk) disable iff (!arst_n) $fell(m_in) |-> $fell(m_reset))
  else flag_mismatch("m_reset", 32'($sampled(m_reset)), 32'h0);

  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (m_reset && !m_reset_prev)
      begin
        rise_cyc <= cyc;
        assert (m_in == 1'b0)
        else fail_run("m_reset rose while m_in was already high");
        // start opcode always rides in the last byte of its frame
        assert (cyc - byte_end_cyc[3] <= reset_cycles + 8)
        else flag_mismatch("m_reset rise delay", cyc - byte_end_cyc[3], reset_cycles + 8);
      end
      if (!m_reset && m_reset_prev)
        fall_cyc <= cyc;
      if (m_in && !m_in_prev)
      begin
        gap = cyc - rise_cyc;
        assert (m_reset == 1'b1)
        else fail_run("m_in rose before m_reset");
        assert ((gap + 1 >= runup_cycles - reset_cycles) &&
                (gap <= runup_cycles - reset_cycles + 1))
        else flag_mismatch("m_in rise delay", gap, runup_cycles - reset_cycles);
      end
      if (!m_in && m_in_prev)
        conv_ends <= conv_ends + 1;
    end
    m_reset_prev = m_reset;
    m_in_prev    = m_in;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    seed        = $urandom(32'ha888);
    arst_n      = 1'b0;
    sck         = 1'b0;
    ssel        = 1'b1;
    mosi        = 1'b0;
    manual_trig = 1'b0;
    start_count = 0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // idle after reset with an empty result
    assert (m_reset == 1'b0) else flag_mismatch("m_reset", 32'(m_reset), 32'h0);
    assert (m_in == 1'b0) else flag_mismatch("m_in", 32'(m_in), 32'h0);
    assert (m_ref == 1'b1) else flag_mismatch("m_ref", 32'(m_ref), 32'h1);
    spi_xfer(32'h0, rdata);
    assert (rdata == 32'h0) else flag_mismatch("result", rdata, 32'h0);

    // full conversions with a different run-down length each
    for (k = 0; k < 3; k++)
    begin
      ends_before = conv_ends;
      spi_xfer({24'h0, op_start}, rdata);
      n = 0;
      while ((conv_ends == ends_before) && (n < wait_limit))
      begin
        @(negedge clk);
        n++;
      end
      if (conv_ends == ends_before)
        fail_run("timeout waiting for the conversion to finish");
      // m_reset rise to comparator rise plus a few cycles of sync latency
      meas = trig_cyc - rise_cyc;
      spi_xfer(32'h0, rdata);
      assert ((rdata + 4 >= meas) && (rdata <= meas + 4))
      else flag_mismatch("result", rdata, meas);
      // unknown opcode is ignored
      spi_xfer({24'h0, 8'h5a}, rdata2);
      assert (rdata2 == rdata) else flag_mismatch("result", rdata2, rdata);
      spi_xfer(32'h0, rdata2);
      assert (rdata2 == rdata) else flag_mismatch("result", rdata2, rdata);
      assert (m_reset == 1'b0) else flag_mismatch("m_reset", 32'(m_reset), 32'h0);
      assert (m_in == 1'b0) else flag_mismatch("m_in", 32'(m_in), 32'h0);
    end

    // abort in the middle of run-up
    spi_xfer({24'h0, op_start}, rdata);
    n = 0;
    while ((m_reset !== 1'b1) && (n < wait_limit))
    begin
      @(negedge clk);
      n++;
    end
    if (m_reset !== 1'b1)
      fail_run("timeout waiting for m_reset to rise");
    // opcode in the first byte so it lands well before run-up ends
    spi_xfer({op_abort, 24'h0}, rdata);
    assert (fall_cyc - byte_end_cyc[0] <= 8)
    else flag_mismatch("m_reset fall delay", fall_cyc - byte_end_cyc[0], 32'd8);
    assert (m_reset == 1'b0) else flag_mismatch("m_reset", 32'(m_reset), 32'h0);
    assert (m_in == 1'b0) else flag_mismatch("m_in", 32'(m_in), 32'h0);
    spi_xfer(32'h0, rdata);
    assert (rdata == 32'h0) else flag_mismatch("result", rdata, 32'h0);

    // comparator edge while idle does nothing
    manual_trig = 1'b1;
    repeat (20) @(negedge clk);
    assert (m_reset == 1'b0) else flag_mismatch("m_reset", 32'(m_reset), 32'h0);
    assert (m_in == 1'b0) else flag_mismatch("m_in", 32'(m_in), 32'h0);
    spi_xfer(32'h0, rdata);
    assert (rdata == 32'h0) else flag_mismatch("result", rdata, 32'h0);
    manual_trig = 1'b0;

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- verilog/adc_ctrl_top.sv
// top level of the dual-slope ADC controller, joining the SPI slave, comparator sync, timer and FSM
`timescale 1ns/1ns

module adc_ctrl_top #(
  parameter logic [adc_pkg::count_w-1:0] RESET_CYCLES = 100000,
  parameter logic [adc_pkg::count_w-1:0] RUNUP_CYCLES = 1000000
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  input  logic t_trigger,
  output logic miso,
  output logic m_reset,
  output logic m_in,
  output logic m_ref
);

  import adc_pkg::*;
  import spi_pkg::*;

  logic [byte_w-1:0]  rx_byte;
  logic               rx_valid;
  logic               cnt_clear;
  logic [count_w-1:0] count;
  logic               reset_done;
  logic               runup_done;
  logic               trig_rise;
  logic [count_w-1:0] result;

  ////////////////////////////////////////////////////////////
  // host side
  ////////////////////////////////////////////////////////////

  spi_slave spi_slave_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .sck      (sck),
    .ssel     (ssel),
    .mosi     (mosi),
    .miso     (miso),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .result   (result)
  );

  ////////////////////////////////////////////////////////////
  // analog side
  ////////////////////////////////////////////////////////////

  // comparator output is asynchronous to clk
  sync_edge trig_sync_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (t_trigger),
    .level  (),
    .rise   (trig_rise),
    .fall   ()
  );

  phase_counter #(
    .RESET_CYCLES (RESET_CYCLES),
    .RUNUP_CYCLES (RUNUP_CYCLES)
  ) phase_counter_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .clear      (cnt_clear),
    .count      (count),
    .reset_done (reset_done),
    .runup_done (runup_done)
  );

  adc_seq_fsm #(
    .RESET_CYCLES (RESET_CYCLES)
  ) adc_seq_fsm_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .reset_done (reset_done),
    .runup_done (runup_done),
    .trig_rise  (trig_rise),
    .count      (count),
    .cnt_clear  (cnt_clear),
    .m_reset    (m_reset),
    .m_in       (m_in),
    .m_ref      (m_ref),
    .result     (result)
  );

endmodule

//--- verilog/adc_seq_fsm.sv
// conversion FSM that decodes host opcodes, drives the analog switches and captures the result
`timescale 1ns/1ns

module adc_seq_fsm #(
  parameter logic [adc_pkg::count_w-1:0] RESET_CYCLES = 100000
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [spi_pkg::byte_w-1:0]   rx_byte,
  input  logic                         rx_valid,
  input  logic                         reset_done,
  input  logic                         runup_done,
  input  logic                         trig_rise,
  input  logic [adc_pkg::count_w-1:0]  count,
  output logic                         cnt_clear,
  output logic                         m_reset,
  output logic                         m_in,
  output logic                         m_ref,
  output logic [adc_pkg::count_w-1:0]  result
);

  import adc_pkg::*;
  import spi_pkg::*;

  adc_state_t state;
  adc_state_t state_nxt;
  spi_op_t    op;
  logic       start_cmd;
  logic       abort_cmd;
  logic       capture;
  logic       m_reset_nxt;
  logic       m_in_nxt;

  ////////////////////////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////////////////////////

  // the byte only means something while rx_valid is high
  assign op        = spi_op_t'(rx_byte);
  assign start_cmd = rx_valid && (op == op_start);
  assign abort_cmd = rx_valid && (op == op_abort);

  // counter restarts on the same edge the FSM enters st_reset
  assign cnt_clear = start_cmd;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt   = state;
    m_reset_nxt = m_reset;
    m_in_nxt    = m_in;
    capture     = 1'b0;
    if (start_cmd)
    begin
      // short the integrator, input switch released
      state_nxt   = st_reset;
      m_reset_nxt = 1'b0;
      m_in_nxt    = 1'b0;
    end
    else if (abort_cmd)
    begin
      state_nxt   = st_idle;
      m_reset_nxt = 1'b0;
      m_in_nxt    = 1'b0;
    end
    else
    begin
      case (state)
        st_reset:
          if (reset_done)
          begin
            // release the short, integrate the input
            state_nxt   = st_runup;
            m_reset_nxt = 1'b1;
          end
        st_runup:
          if (runup_done)
          begin
            // swap to the reference for run-down
            state_nxt = st_rundown;
            m_in_nxt  = 1'b1;
          end
        st_rundown:
          if (trig_rise)
          begin
            // comparator crossed, conversion done
            capture     = 1'b1;
            state_nxt   = st_idle;
            m_reset_nxt = 1'b0;
            m_in_nxt    = 1'b0;
          end
        default:
          state_nxt = st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= st_idle;
      m_reset <= 1'b0;
      m_in    <= 1'b0;
      m_ref   <= 1'b1;
      result  <= '0;
    end
    else
    begin
      state   <= state_nxt;
      m_reset <= m_reset_nxt;
      m_in    <= m_in_nxt;
      // switch is either on the input or on the reference
      m_ref   <= ~m_in_nxt;
      // cleared on start so a read mid-conversion returns 0
      if (start_cmd)
        result <= '0;
      else if (capture)
        result <= count - RESET_CYCLES;
    end
  end

endmodule

//--- verilog/phase_counter.sv
// conversion timer that counts clock cycles and flags the end of the reset and run-up phases
`timescale 1ns/1ns

module phase_counter #(
  parameter logic [adc_pkg::count_w-1:0] RESET_CYCLES = 100000,
  parameter logic [adc_pkg::count_w-1:0] RUNUP_CYCLES = 1000000
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         clear,
  output logic [adc_pkg::count_w-1:0]  count,
  output logic                         reset_done,
  output logic                         runup_done
);

  import adc_pkg::*;

  ////////////////////////////////////////////////////////////
  // cycle counter
  ////////////////////////////////////////////////////////////

  // free running, restarted by the sequencer on op_start
  // wraps silently, the sequencer only looks at it mid-conversion
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      count <= '0;
    else if (clear)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // phase ends
  ////////////////////////////////////////////////////////////

  // exact compare, so each flag is high for a single cycle per pass
  assign reset_done = (count == RESET_CYCLES);
  assign runup_done = (count == RUNUP_CYCLES);

endmodule

//--- spi/spi_slave.sv
// mode-0 SPI slave that receives command bytes and shifts the stored result out on miso
`timescale 1ns/1ns

module spi_slave (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         sck,
  input  logic                         ssel,
  input  logic                         mosi,
  output logic                         miso,
  output logic [spi_pkg::byte_w-1:0]   rx_byte,
  output logic                         rx_valid,
  input  logic [adc_pkg::count_w-1:0]  result
);

  import adc_pkg::*;
  import spi_pkg::*;

  localparam int unsigned bit_cnt_w = $clog2(byte_w);
  localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(byte_w - 1);

  logic                 sck_rise;
  logic                 sck_fall;
  logic                 ssel_level;
  logic                 ssel_fall;
  logic                 mosi_level;
  logic                 ssel_active;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [byte_w-1:0]    rx_shift;
  logic [count_w-1:0]   tx_shift;

  ////////////////////////////////////////////////////////////
  // pin synchronizers
  ////////////////////////////////////////////////////////////

  // all three pins share the same latency, so mosi lines up with sck
  sync_edge sck_sync_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (sck),
    .level  (),
    .rise   (sck_rise),
    .fall   (sck_fall)
  );

  sync_edge ssel_sync_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (ssel),
    .level  (ssel_level),
    .rise   (),
    .fall   (ssel_fall)
  );

  sync_edge mosi_sync_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (mosi),
    .level  (mosi_level),
    .rise   (),
    .fall   ()
  );

  // ssel is active low
  assign ssel_active = ~ssel_level;

  ////////////////////////////////////////////////////////////
  // receive path
  ////////////////////////////////////////////////////////////

  // bit counter sits at zero between frames
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      if (!ssel_active)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 1'b1;
      // strobe one cycle after the last rising sck of the byte
      rx_valid <= ssel_active && sck_rise && (bit_cnt == last_bit);
    end
  end

  // msb first, so shift in from the right
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
      rx_shift <= {rx_shift[byte_w-2:0], mosi_level};
  end

  assign rx_byte = rx_shift;

  ////////////////////////////////////////////////////////////
  // transmit path
  ////////////////////////////////////////////////////////////

  // snapshot of result at frame start, then one bit per falling sck
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      tx_shift <= '0;
    else if (ssel_fall)
      tx_shift <= result;
    else if (ssel_active && sck_fall)
      tx_shift <= {tx_shift[count_w-2:0], 1'b0};
  end

  // single slave on the bus, miso is always driven
  assign miso = tx_shift[count_w-1];

endmodule

//--- verilog/sync_edge.sv
// two-stage synchronizer for one asynchronous pin, giving the clean level and edge pulses
`timescale 1ns/1ns

module sync_edge (
  input  logic clk,
  input  logic arst_n,
  input  logic din,
  output logic level,
  output logic rise,
  output logic fall
);

  // sync_sr[0] may go metastable
  // sync_sr[1] is the clean level
  // sync_sr[2] holds the previous level for edge detection
  logic [2:0] sync_sr;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_sr <= 3'b000;
    end
    else
    begin
      sync_sr <= {sync_sr[1:0], din};
    end
  end

  assign level = sync_sr[1];
  // single-cycle pulses, two cycles after the pin moves
  assign rise  = sync_sr[1] & ~sync_sr[2];
  assign fall  = ~sync_sr[1] & sync_sr[2];

endmodule

//--- common/spi_pkg.sv
// host protocol types for the SPI command byte, used by the SPI slave and the sequencer
package spi_pkg;

  ////////////////////////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////////////////////////

  // bits per received command byte, sent msb first
  localparam int unsigned byte_w = 8;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////

  // op_start clears the counter and the last result
  // then runs one full conversion
  // op_abort drops back to idle and keeps the result
  // any other byte value is ignored by the sequencer
  typedef enum logic [byte_w-1:0] {
    op_start = 8'hcc,
    op_abort = 8'h33
  } spi_op_t;

  // every frame also shifts the stored result out on miso
  // so a read needs no opcode of its own

endpackage

//--- common/adc_pkg.sv
// conversion control types shared by the sequencer, the phase counter and the top level
package adc_pkg;

  ////////////////////////////////////////////////////////////
  // counter sizing
  ////////////////////////////////////////////////////////////

  // width of the phase counter and of the captured result
  // 32 bits covers well over a second of run-up at 100 MHz
  localparam int unsigned count_w = 32;

  ////////////////////////////////////////////////////////////
  // conversion state
  ////////////////////////////////////////////////////////////

  // st_idle
  //   waiting for a start opcode, switches released
  // st_reset
  //   integrator shorted, counter running toward RESET_CYCLES
  // st_runup
  //   integrator takes the input until RUNUP_CYCLES
  // st_rundown
  //   integrator takes the reference until the comparator rises
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_reset   = 2'd1,
    st_runup   = 2'd2,
    st_rundown = 2'd3
  } adc_state_t;

  // a full conversion walks the states in enum order
  // and falls back to st_idle on the comparator edge
  // an abort opcode may cut in from any state

endpackage
